// ==== include/gal_macros.svh ====
`ifndef GAL_MACROS_SVH
`define GAL_MACROS_SVH

// --------------------------------------------------
// cascade size and arithmetic format
// --------------------------------------------------

`define GAL_STAGES    4    // lattice stages in the cascade
`define GAL_DW        16   // bits per real or imag part
`define GAL_QSHIFT    15   // Q15 product alignment

// stage address, must cover GAL_STAGES
`define GAL_AW        2

// --------------------------------------------------
// pipeline timing
// --------------------------------------------------

`define GAL_STAGE_LAT 2    // multiplier reg + adder reg

`endif

// ==== verilog/gal_pkg.sv ====
`default_nettype none

package gal_pkg;

  `include "gal_macros.svh"

  // --------------------------------------------------
  // complex Q15 value, real part in the upper half
  // --------------------------------------------------
  typedef struct packed {
    logic signed [`GAL_DW-1:0] re;  // upper half
    logic signed [`GAL_DW-1:0] im;  // lower half
  } cplx_t;

  // --------------------------------------------------
  // configuration command opcodes
  // --------------------------------------------------
  typedef enum logic [1:0] {
    op_nop   = 2'd0,  // idle
    op_write = 2'd1,  // load one stage kappa
    op_clear = 2'd2   // zero all kappas
  } cfg_op_t;

endpackage

`default_nettype wire

// ==== verilog/gal_kappa_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gal_macros.svh"

module gal_kappa_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  gal_pkg::cfg_op_t      cfg_op,
  input  logic [`GAL_AW-1:0]    cfg_addr,
  input  gal_pkg::cplx_t        cfg_data,
  output gal_pkg::cplx_t        kappa [`GAL_STAGES]
);

  import gal_pkg::*;

  logic addr_ok;  // address names a real stage

  assign addr_ok = (int'(cfg_addr) < `GAL_STAGES);

  // --------------------------------------------------
  // command decode
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 0; i < `GAL_STAGES; i++) begin
        kappa[i] <= '0;
      end
    end else begin
      case (cfg_op)
        op_write: begin
          if (addr_ok) begin
            kappa[cfg_addr] <= cfg_data;  // out of range writes dropped
          end
        end
        op_clear: begin
          for (int i = 0; i < `GAL_STAGES; i++) begin
            kappa[i] <= '0;  // cascade becomes a plain delay
          end
        end
        default: begin
          // op_nop, keep everything
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gal_cmult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gal_macros.svh"

module gal_cmult #(
  parameter bit CONJ = 1'b0  // 1: use conj(k)
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            en,
  input  gal_pkg::cplx_t  k,
  input  gal_pkg::cplx_t  x,
  output gal_pkg::cplx_t  p
);

  // full precision partial products
  logic signed [2*`GAL_DW-1:0] prod_rr;
  logic signed [2*`GAL_DW-1:0] prod_ii;
  logic signed [2*`GAL_DW-1:0] prod_ri;
  logic signed [2*`GAL_DW-1:0] prod_ir;

  // one guard bit for the sum of two products
  logic signed [2*`GAL_DW:0]   sum_re;
  logic signed [2*`GAL_DW:0]   sum_im;
  logic signed [2*`GAL_DW:0]   shr_re;
  logic signed [2*`GAL_DW:0]   shr_im;

  assign prod_rr = $signed(k.re) * $signed(x.re);
  assign prod_ii = $signed(k.im) * $signed(x.im);
  assign prod_ri = $signed(k.re) * $signed(x.im);
  assign prod_ir = $signed(k.im) * $signed(x.re);

  // --------------------------------------------------
  // combine, conj flips every k.im term
  // --------------------------------------------------
  always_comb begin
    if (CONJ) begin
      sum_re = prod_rr + prod_ii;
      sum_im = prod_ri - prod_ir;
    end else begin
      sum_re = prod_rr - prod_ii;
      sum_im = prod_ri + prod_ir;
    end
  end

  assign shr_re = sum_re >>> `GAL_QSHIFT;  // back to Q15
  assign shr_im = sum_im >>> `GAL_QSHIFT;

  always_ff @(posedge clk) begin
    if (!reset) begin
      p <= '0;
    end else if (en) begin
      p.re <= shr_re[`GAL_DW-1:0];  // truncate, low bits kept
      p.im <= shr_im[`GAL_DW-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gal_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module gal_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  input  gal_pkg::cplx_t  f_in,
  input  gal_pkg::cplx_t  b_in,
  input  gal_pkg::cplx_t  kappa,
  output logic            out_valid,
  output gal_pkg::cplx_t  f_out,
  output gal_pkg::cplx_t  b_out
);

  import gal_pkg::*;

  cplx_t b_prev;     // backward input of the previous valid sample
  cplx_t f_dly;      // f lined up with the products
  cplx_t bp_dly;     // b_prev lined up with the products
  cplx_t kb_prod;    // kappa * b_prev
  cplx_t kf_prod;    // conj(kappa) * f
  logic  valid_dly;

  // --------------------------------------------------
  // cycle one: products and aligned operands
  // --------------------------------------------------
  gal_cmult #(
    .CONJ (1'b0)
  ) u_mult_kb (
    .clk   (clk),
    .reset (reset),
    .en    (in_valid),
    .k     (kappa),
    .x     (b_prev),
    .p     (kb_prod)
  );

  gal_cmult #(
    .CONJ (1'b1)
  ) u_mult_kf (
    .clk   (clk),
    .reset (reset),
    .en    (in_valid),
    .k     (kappa),
    .x     (f_in),
    .p     (kf_prod)
  );

  // advances per sample, not per cycle
  always_ff @(posedge clk) begin
    if (!reset) begin
      b_prev <= '0;
    end else if (in_valid) begin
      b_prev <= b_in;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      f_dly  <= f_in;
      bp_dly <= b_prev;  // value before this sample's update
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      valid_dly <= 1'b0;
    end else begin
      valid_dly <= in_valid;
    end
  end

  // --------------------------------------------------
  // cycle two: update adders, 16 bit wrap per part
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset) begin
      out_valid <= 1'b0;
      f_out     <= '0;
      b_out     <= '0;
    end else begin
      out_valid <= valid_dly;
      if (valid_dly) begin
        f_out.re <= f_dly.re + kb_prod.re;
        f_out.im <= f_dly.im + kb_prod.im;
        b_out.re <= bp_dly.re + kf_prod.re;
        b_out.im <= bp_dly.im + kf_prod.im;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gal_lattice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gal_macros.svh"

module gal_lattice (
  input  logic                clk,
  input  logic                reset,
  input  gal_pkg::cfg_op_t    cfg_op,
  input  logic [`GAL_AW-1:0]  cfg_addr,
  input  gal_pkg::cplx_t      cfg_data,
  input  logic                in_valid,
  input  gal_pkg::cplx_t      in_sample,
  output logic                out_valid,
  output gal_pkg::cplx_t      f_out,
  output gal_pkg::cplx_t      b_out
);

  import gal_pkg::*;

  cplx_t              in_reg;    // feeds both f and b of stage 0
  logic               in_vld_reg;
  cplx_t              kappa   [`GAL_STAGES];
  cplx_t              f_chain [`GAL_STAGES+1];
  cplx_t              b_chain [`GAL_STAGES+1];
  logic [`GAL_STAGES:0] v_chain;

  // --------------------------------------------------
  // input register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (in_valid) begin
      in_reg <= in_sample;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      in_vld_reg <= 1'b0;
    end else begin
      in_vld_reg <= in_valid;
    end
  end

  assign f_chain[0] = in_reg;
  assign b_chain[0] = in_reg;
  assign v_chain[0] = in_vld_reg;

  gal_kappa_regs u_kappa (
    .clk      (clk),
    .reset    (reset),
    .cfg_op   (cfg_op),
    .cfg_addr (cfg_addr),
    .cfg_data (cfg_data),
    .kappa    (kappa)
  );

  // --------------------------------------------------
  // stage chain
  // --------------------------------------------------
  for (genvar i = 0; i < `GAL_STAGES; i++) begin : g_stage
    gal_stage u_stage (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (v_chain[i]),
      .f_in      (f_chain[i]),
      .b_in      (b_chain[i]),
      .kappa     (kappa[i]),
      .out_valid (v_chain[i+1]),
      .f_out     (f_chain[i+1]),
      .b_out     (b_chain[i+1])
    );
  end

  assign out_valid = v_chain[`GAL_STAGES];  // last stage only
  assign f_out     = f_chain[`GAL_STAGES];
  assign b_out     = b_chain[`GAL_STAGES];

endmodule

`default_nettype wire

// ==== test/gal_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module gal_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b0;  // active low
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/gal_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gal_macros.svh"

module gal_chk (
  input logic                clk,
  input logic                reset,
  input gal_pkg::cfg_op_t    cfg_op,
  input logic [`GAL_AW-1:0]  cfg_addr,
  input logic                in_valid,
  input logic                out_valid,
  input gal_pkg::cplx_t      f_out,
  input gal_pkg::cplx_t      b_out
);

  import gal_pkg::*;

  localparam int LAT = 1 + `GAL_STAGE_LAT * `GAL_STAGES;

  int fail_count = 0;  // read by the testbench top

  // --------------------------------------------------
  // top level timing and command rules
  // --------------------------------------------------
  a_latency: assert property (@(posedge clk) disable iff (!reset)
    out_valid == $past(in_valid, LAT))
    else begin
      fail_count++;
      $error("out_valid does not follow in_valid by %0d cycles", LAT);
    end

  a_known_out: assert property (@(posedge clk) disable iff (!reset)
    out_valid |-> !$isunknown({f_out, b_out}))
    else begin
      fail_count++;
      $error("unknown bits on f_out or b_out while out_valid is high");
    end

  a_write_addr: assert property (@(posedge clk) disable iff (!reset)
    (cfg_op == op_write) |-> (int'(cfg_addr) < `GAL_STAGES))
    else begin
      fail_count++;
      $error("kappa write to a stage address that does not exist");
    end

endmodule

bind gal_lattice gal_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .cfg_op    (cfg_op),
  .cfg_addr  (cfg_addr),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .f_out     (f_out),
  .b_out     (b_out)
);

`default_nettype wire

// ==== test/gal_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gal_macros.svh"

module gal_monitor (
  input  logic                clk,
  input  logic                reset,
  input  gal_pkg::cfg_op_t    cfg_op,
  input  logic [`GAL_AW-1:0]  cfg_addr,
  input  gal_pkg::cplx_t      cfg_data,
  input  logic                in_valid,
  input  gal_pkg::cplx_t      in_sample,
  input  logic [8*12-1:0]     test_name,
  input  logic                out_valid,
  input  gal_pkg::cplx_t      f_out,
  input  gal_pkg::cplx_t      b_out,
  output int                  pending
);

  import gal_pkg::*;

  cplx_t          kap [`GAL_STAGES];  // model kappas
  cplx_t          bp  [`GAL_STAGES];  // model b_prev per stage
  cplx_t          exp_f_q [$];
  cplx_t          exp_b_q [$];
  logic [8*12-1:0] name_q [$];
  cplx_t          ef, eb;
  logic [8*12-1:0] nm;
  int             mism_errs = 0;
  int             proto_errs = 0;
  bit             seen_sample;

  // --------------------------------------------------
  // reference arithmetic
  // --------------------------------------------------
  function automatic cplx_t cmul(input cplx_t k, input cplx_t x, input bit conj);
    longint kr, ki, xr, xi, pr, pi;
    cplx_t  p;
    kr = longint'($signed(k.re));
    ki = longint'($signed(k.im));
    xr = longint'($signed(x.re));
    xi = longint'($signed(x.im));
    if (conj) ki = -ki;  // conj(k)
    pr = (kr * xr - ki * xi) >>> `GAL_QSHIFT;
    pi = (kr * xi + ki * xr) >>> `GAL_QSHIFT;
    p.re = pr[`GAL_DW-1:0];
    p.im = pi[`GAL_DW-1:0];
    return p;
  endfunction

  function automatic cplx_t cadd(input cplx_t a, input cplx_t b);
    cplx_t s;
    s.re = a.re + b.re;  // wraps at 16 bits
    s.im = a.im + b.im;
    return s;
  endfunction

  // whole cascade for one sample, b_prev advances here
  task automatic step_model(input cplx_t x, output cplx_t fo, output cplx_t bo);
    cplx_t f, b, fn, bn;
    f = x;
    b = x;
    for (int s = 0; s < `GAL_STAGES; s++) begin
      fn    = cadd(f, cmul(kap[s], bp[s], 1'b0));
      bn    = cadd(bp[s], cmul(kap[s], f, 1'b1));
      bp[s] = b;
      f     = fn;
      b     = bn;
    end
    fo = f;
    bo = b;
  endtask

  task automatic compare(input logic [8*12-1:0] name, input cplx_t e, input cplx_t a,
                         input logic [8*8-1:0] port);
    if (a !== e) begin
      $display("ERR %0s %0s expected %08h actual %08h", name, port, e, a);
      mism_errs++;
    end
  endtask

  // --------------------------------------------------
  // watch ports, outputs before new inputs
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!reset) begin
      for (int s = 0; s < `GAL_STAGES; s++) begin
        kap[s] = '0;
        bp[s]  = '0;
      end
      exp_f_q.delete();
      exp_b_q.delete();
      name_q.delete();
      seen_sample = 1'b0;
    end else begin
      if (out_valid) begin
        if (exp_f_q.size() == 0) begin
          $display("out_valid at %0t with no sample pending", $time);
          proto_errs++;
        end else begin
          ef = exp_f_q.pop_front();
          eb = exp_b_q.pop_front();
          nm = name_q.pop_front();
          compare(nm, ef, f_out, "f_out");
          compare(nm, eb, b_out, "b_out");
        end
      end else if (!seen_sample && (f_out !== '0 || b_out !== '0)) begin
        $display("outputs are not zero after reset at %0t", $time);
        proto_errs++;
      end
      case (cfg_op)
        op_write: if (int'(cfg_addr) < `GAL_STAGES) kap[cfg_addr] = cfg_data;
        op_clear: for (int s = 0; s < `GAL_STAGES; s++) kap[s] = '0;
        default: ;
      endcase
      if (in_valid) begin
        seen_sample = 1'b1;
        step_model(in_sample, ef, eb);
        exp_f_q.push_back(ef);
        exp_b_q.push_back(eb);
        name_q.push_back(test_name);
      end
    end
    pending = exp_f_q.size();
  end

  task automatic report(input int assert_fails, output int total);
    if (exp_f_q.size() != 0) begin
      $display("%0d expected outputs never came out of the DUT", exp_f_q.size());
      proto_errs++;
    end
    $display("error counts: mismatches %0d, protocol %0d, assertions %0d",
             mism_errs, proto_errs, assert_fails);
    total = mism_errs + proto_errs + assert_fails;
  endtask

endmodule

`default_nettype wire

// ==== test/gal_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gal_macros.svh"

module gal_tb;

  import gal_pkg::*;

  typedef struct packed {
    logic [8*12-1:0]    name;
    bit                 is_cmd;
    cfg_op_t            op;
    logic [`GAL_AW-1:0] addr;
    cplx_t              data;
    int                 gap;  // idle cycles after the row
  } row_t;

  localparam int LAT    = 1 + `GAL_STAGE_LAT * `GAL_STAGES;
  localparam int MARGIN = 20;

  logic               clk, reset;
  cfg_op_t            cfg_op;
  logic [`GAL_AW-1:0] cfg_addr;
  cplx_t              cfg_data, in_sample, f_out, b_out;
  logic               in_valid, out_valid;
  logic [8*12-1:0]    cur_name;
  int                 pending, limit, cycles, total;
  row_t               rows [$];

  gal_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clk (.clk(clk), .reset(reset));

  gal_lattice DUT (
    .clk (clk), .reset (reset), .cfg_op (cfg_op), .cfg_addr (cfg_addr),
    .cfg_data (cfg_data), .in_valid (in_valid), .in_sample (in_sample),
    .out_valid (out_valid), .f_out (f_out), .b_out (b_out)
  );

  gal_monitor u_mon (
    .clk (clk), .reset (reset), .cfg_op (cfg_op), .cfg_addr (cfg_addr),
    .cfg_data (cfg_data), .in_valid (in_valid), .in_sample (in_sample),
    .test_name (cur_name), .out_valid (out_valid), .f_out (f_out),
    .b_out (b_out), .pending (pending)
  );

  function automatic cplx_t full_scale_val(input int i);
    case (i % 4)
      0:       return cplx_t'(32'h7fff_0000);
      1:       return cplx_t'(32'h8000_7fff);
      2:       return cplx_t'(32'h7fff_7fff);
      default: return cplx_t'(32'h8000_8000);
    endcase
  endfunction

  task automatic add_row(input logic [8*12-1:0] name, input bit is_cmd, input cfg_op_t op,
                         input int addr, input cplx_t data, input int gap);
    row_t r;
    r.name   = name;
    r.is_cmd = is_cmd;
    r.op     = op;
    r.addr   = addr[`GAL_AW-1:0];
    r.data   = data;
    r.gap    = gap;
    rows.push_back(r);
    limit += 1 + gap;
  endtask

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  task automatic build_table();
    add_row("reset_idle", 1'b1, op_nop, 0, '0, 12);
    for (int i = 0; i < 8; i++) begin
      add_row("zero_kappa", 1'b0, op_nop, 0, $urandom(), (i == 7) ? 10 : 0);
    end
    for (int i = 0; i < `GAL_STAGES; i++) begin
      add_row("kappa_write", 1'b1, op_write, i, $urandom(), 0);
    end
    for (int i = 0; i < 12; i++) begin
      add_row("back_to_back", 1'b0, op_nop, 0, $urandom(), (i == 11) ? 10 : 0);
    end
    for (int i = 0; i < 12; i++) begin
      add_row("random_gaps", 1'b0, op_nop, 0, $urandom(), (i == 11) ? 10 : $urandom_range(3, 0));
    end
    for (int i = 0; i < `GAL_STAGES; i++) begin
      add_row("full_scale", 1'b1, op_write, i, full_scale_val(i), 0);
    end
    for (int i = 0; i < 8; i++) begin
      add_row("full_scale", 1'b0, op_nop, 0, full_scale_val(i + 1), (i == 7) ? 10 : 0);
    end
    add_row("clear", 1'b1, op_clear, 0, '0, 0);
    for (int i = 0; i < 8; i++) begin
      add_row("after_clear", 1'b0, op_nop, 0, $urandom(), (i == 7) ? 10 : 0);
    end
    limit += LAT + MARGIN;
  endtask

  task automatic drive_idle();
    cfg_op   = op_nop;
    in_valid = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    @(negedge clk);
    drive_idle();
    cur_name = r.name;
    if (r.is_cmd) begin
      cfg_op   = r.op;
      cfg_addr = r.addr;
      cfg_data = r.data;
    end else begin
      in_valid  = 1'b1;
      in_sample = r.data;
    end
    repeat (r.gap) begin
      @(negedge clk);
      drive_idle();
    end
  endtask

  initial begin
    cfg_op    = op_nop;
    cfg_addr  = '0;
    cfg_data  = '0;
    in_valid  = 1'b0;
    in_sample = '0;
    cur_name  = "idle";
    limit     = 0;
    void'($urandom(47045));
    build_table();
    wait (reset === 1'b1);
    for (int i = 0; i < rows.size(); i++) apply_row(rows[i]);
    @(negedge clk);
    drive_idle();
    while (pending != 0) @(negedge clk);  // drain the pipeline
    repeat (2) @(negedge clk);
    u_mon.report(DUT.u_chk.fail_count, total);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // --------------------------------------------------
  // timeout
  // --------------------------------------------------
  initial begin
    cycles = 0;
    wait (reset === 1'b1);
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycles);
    u_mon.report(DUT.u_chk.fail_count, total);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
verilog/gal_pkg.sv
verilog/gal_kappa_regs.sv
verilog/gal_cmult.sv
verilog/gal_stage.sv
verilog/gal_lattice.sv
test/gal_clk_gen.sv
test/gal_chk.sv
test/gal_monitor.sv
test/gal_tb.sv

// ==== Bender.yml ====
package:
  name: gal_lattice

export_include_dirs:
  - include

sources:
  - files:
      - verilog/gal_pkg.sv
      - verilog/gal_kappa_regs.sv
      - verilog/gal_cmult.sv
      - verilog/gal_stage.sv
      - verilog/gal_lattice.sv
  - target: test
    files:
      - test/gal_clk_gen.sv
      - test/gal_chk.sv
      - test/gal_monitor.sv
      - test/gal_tb.sv
